/* mem_tests.txt */
# kind(S store, L load, N none) size(0 byte, 1 half, 2 word) signed(1 = lb/lh)
# addr(hex) wdata(hex) expected_load(hex) inst_id(hex)
S 2 0 00000010 89abcdef 00000000 01
S 2 0 00000014 00000000 00000000 02
S 0 0 00000014 000000a5 00000000 03
S 0 0 00000015 0000007f 00000000 04
S 0 0 00000016 00000080 00000000 05
S 0 0 00000017 123456c3 00000000 06
S 2 0 00000018 00000000 00000000 07
S 1 0 00000018 0000f00d 00000000 08
S 1 0 0000001a 00001234 00000000 09
S 0 0 00000011 55555555 00000000 0a
L 2 1 00000010 00000000 89ab55ef 0b
L 0 1 00000014 00000000 ffffffa5 0c
L 0 0 00000014 00000000 000000a5 0d
L 0 1 00000015 00000000 0000007f 0e
L 0 1 00000016 00000000 ffffff80 0f
L 0 0 00000017 00000000 000000c3 10
L 1 1 00000018 00000000 fffff00d 11
L 1 0 00000018 00000000 0000f00d 12
L 1 1 0000001a 00000000 00001234 13
L 1 0 00000012 00000000 000089ab 14
L 2 0 00000014 00000000 c3807fa5 15
N 0 0 00000000 00000000 00000000 16
S 0 0 00000013 00000042 00000000 17
L 2 0 00000010 00000000 42ab55ef 17
L 0 1 00000013 00000000 00000042 18
L 0 1 00000017 00000000 ffffffc3 19

/* mem_subsystem.f */
mem_types_pkg.sv
mem_bus_pkg.sv
mem_stage_ctrl.sv
store_aligner.sv
load_extender.sv
data_mem.sv
mem_subsystem.sv
mem_subsystem_sva.sv
tb_mem_subsystem.sv

/* Makefile */
TOOL     = verilator
TOP      = tb_mem_subsystem
FILELIST = mem_subsystem.f
FLAGS    = --timing --assert --timescale 1ns/1ps
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb_mem_subsystem.sv */
module tb_mem_subsystem
    import mem_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int STALL_LIMIT = 40;  // cycles, well past the memory busy period

    logic      clk;
    logic      reset;
    logic      mem_valid;
    inst_id_t  inst_id;
    mem_ctrl_t ctrl;
    addr_t     alu_out;
    word_t     rs2_data;
    logic      wb_valid;
    word_t     wb_rdata;
    logic      stall;

    word_t model [256];  // reference copy of the memory contents
    int    seed;
    int    n_vec;

    mem_subsystem uut (
        .clk       (clk),
        .reset     (reset),
        .mem_valid (mem_valid),
        .inst_id   (inst_id),
        .ctrl      (ctrl),
        .alu_out   (alu_out),
        .rs2_data  (rs2_data),
        .wb_valid  (wb_valid),
        .wb_rdata  (wb_rdata),
        .stall     (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("ERROR: t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // byte goes to lane addr[1:0], halfword to the half picked by addr[1]
    function automatic word_t merge_store(word_t old, addr_t addr, int size, word_t data);
        word_t w;
        int    lane;
        w    = old;
        lane = int'(addr[1:0]);
        case (size)
            0:       w[8*lane +: 8] = data[7:0];
            1:       w[16*(lane/2) +: 16] = data[15:0];
            default: w = data;
        endcase
        return w;
    endfunction

    function automatic word_t extract_load(word_t w, addr_t addr, int size, int sgn);
        int          lane;
        logic [7:0]  b;
        logic [15:0] h;
        word_t       r;
        lane = int'(addr[1:0]);
        b    = w[8*lane +: 8];
        h    = w[16*(lane/2) +: 16];
        case (size)
            0:       r = (sgn != 0) ? {{24{b[7]}}, b} : {24'h0, b};
            1:       r = (sgn != 0) ? {{16{h[15]}}, h} : {16'h0, h};
            default: r = w;
        endcase
        return r;
    endfunction

    task automatic wait_stall_release(input inst_id_t id);
        int cycles;
        cycles = 0;
        while (stall) begin
            @(negedge clk);
            cycles++;
            if (cycles > STALL_LIMIT) begin
                $display("stall never released for instruction id %h", id);
                $display("TEST FAIL");
                $fatal(1, "stall timeout");
            end
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic run_access(input logic [7:0] kind, input int size, input int sgn,
                              input addr_t addr, input word_t wdata, input word_t exp,
                              input inst_id_t id);
        mem_sel_e sel;
        int       hold;
        sel  = (kind == "S") ? MEM_STORE :
               (kind == "N") ? MEM_NONE :
               (sgn != 0)    ? MEM_LOAD_S : MEM_LOAD_U;
        hold = 0;  // next access follows right away, memory may still be busy
        if ($random(seed) & 1) begin
            hold = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
        end
        mem_valid = 1'b1;
        inst_id   = id;
        ctrl.sel  = sel;
        ctrl.size = mem_size_e'(size[1:0]);
        alu_out   = addr;
        rs2_data  = wdata;
        #1;
        check_value("wb_valid", word_t'(wb_valid), 32'd1);
        if (sel == MEM_NONE) begin
            check_value("stall", word_t'(stall), 32'd0);
            @(negedge clk);
            check_value("stall", word_t'(stall), 32'd0);
        end else begin
            check_value("stall", word_t'(stall), 32'd1);  // same-cycle raise
            wait_stall_release(id);
            if (sel != MEM_STORE) begin
                check_value("wb_rdata", wb_rdata, exp);
            end
            // held instruction must not go to memory again
            repeat (hold) begin
                @(negedge clk);
                check_value("stall", word_t'(stall), 32'd0);
                if (sel != MEM_STORE) begin
                    check_value("wb_rdata", wb_rdata, exp);
                end
            end
        end
    endtask

    initial begin
        int                 fd;
        int                 r;
        int                 size;
        int                 sgn;
        int                 gap;
        logic [7:0]         kind;
        logic [8*128-1:0]   rest;
        addr_t              addr;
        word_t              wdata;
        word_t              exp;
        word_t              ref_val;
        inst_id_t           id;
        inst_id_t           prev_id;
        logic               first;

        seed      = 85;
        reset     = 1'b1;
        mem_valid = 1'b0;
        inst_id   = '0;
        ctrl.sel  = MEM_NONE;
        ctrl.size = SIZE_W;
        alu_out   = '0;
        rs2_data  = '0;
        n_vec     = 0;
        first     = 1'b1;
        prev_id   = '0;
        foreach (model[i]) model[i] = '0;

        fd = $fopen("mem_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file mem_tests.txt");
            $display("TEST FAIL");
            $fatal(1, "no vectors");
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("stall", word_t'(stall), 32'd0);
        check_value("wb_valid", word_t'(wb_valid), 32'd0);

        while (!$feof(fd)) begin
            r = $fscanf(fd, " %c", kind);
            if (r != 1) break;
            if (kind == 8'h23) begin  // comment line
                r = $fgets(rest, fd);
                continue;
            end
            r = $fscanf(fd, "%d %d %h %h %h %h", size, sgn, addr, wdata, exp, id);
            if (r != 6) begin
                $display("malformed line in mem_tests.txt after %0d vectors", n_vec);
                $display("TEST FAIL");
                $fatal(1, "bad vector file");
            end

            gap = (($random(seed) & 3) == 0) ? 1 : 0;
            if (!first && id == prev_id) gap = gap + 1;  // reused id needs a bubble
            repeat (gap) begin
                mem_valid = 1'b0;
                @(negedge clk);
                check_value("stall", word_t'(stall), 32'd0);
                check_value("wb_valid", word_t'(wb_valid), 32'd0);
            end

            if (kind == "S") begin
                model[addr[9:2]] = merge_store(model[addr[9:2]], addr, size, wdata);
            end else if (kind == "L") begin
                ref_val = extract_load(model[addr[9:2]], addr, size, sgn);
                check_value("expected value in file", exp, ref_val);
            end

            run_access(kind, size, sgn, addr, wdata, exp, id);
            prev_id = id;
            first   = 1'b0;
            n_vec++;
        end
        $fclose(fd);

        if (n_vec == 0) begin
            $display("no vectors were read from mem_tests.txt");
            $display("TEST FAIL");
            $fatal(1, "empty vector file");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* mem_subsystem_sva.sv */
module mem_subsystem_sva
    import mem_types_pkg::*;
    import mem_bus_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      mem_valid,
    input mem_ctrl_t ctrl,
    input logic      ready,
    input dreq_t     req,
    input logic      stall
);

    timeunit 1ns;
    timeprecision 100ps;

    // no request without an instruction in the stage
    req_needs_valid: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> mem_valid)
        else $error("request valid while mem_valid is low");

    no_stall_on_none: assert property (@(posedge clk) disable iff (reset)
        (ctrl.sel == MEM_NONE) |-> !stall)  // non-memory ops pass straight through
        else $error("stall high for a non-memory instruction");

    // request held steady until memory takes it
    req_stable_while_waiting: assert property (@(posedge clk) disable iff (reset)
        (req.valid && !ready) |=> $stable(req))
        else $error("request changed before it was accepted");

endmodule

bind mem_stage_ctrl mem_subsystem_sva u_sva (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .ctrl      (ctrl),
    .ready     (ready),
    .req       (req),
    .stall     (stall)
);

/* mem_subsystem.sv */
module mem_subsystem
    import mem_types_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int DEPTH_WORDS = 256,
    parameter int LATENCY     = 2
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      mem_valid,
    input  inst_id_t  inst_id,
    input  mem_ctrl_t ctrl,
    input  addr_t     alu_out,
    input  word_t     rs2_data,
    output logic      wb_valid,
    output word_t     wb_rdata,
    output logic      stall
);

    word_t      st_wdata;
    byte_mask_t st_mask;
    word_t      rdata_q;
    dreq_t      req;
    dresp_t     resp;
    logic       ready;

    assign wb_valid = mem_valid;  // stage never drops an instruction

    mem_stage_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .mem_valid (mem_valid),
        .inst_id   (inst_id),
        .ctrl      (ctrl),
        .alu_out   (alu_out),
        .st_wdata  (st_wdata),
        .st_mask   (st_mask),
        .ready     (ready),
        .resp      (resp),
        .req       (req),
        .rdata_q   (rdata_q),
        .stall     (stall)
    );

    store_aligner u_store (
        .byte_off (alu_out[1:0]),
        .size     (ctrl.size),
        .data     (rs2_data),
        .wdata    (st_wdata),
        .wmask    (st_mask)
    );

    // works on the registered read word
    load_extender u_load (
        .byte_off (alu_out[1:0]),
        .ctrl     (ctrl),
        .word     (rdata_q),
        .result   (wb_rdata)
    );

    data_mem #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .LATENCY     (LATENCY)
    ) u_dmem (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .ready (ready),
        .resp  (resp)
    );

endmodule

/* data_mem.sv */
module data_mem
    import mem_types_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int DEPTH_WORDS = 256,
    parameter int LATENCY     = 2
) (
    input  logic   clk,
    input  logic   reset,
    input  dreq_t  req,
    output logic   ready,
    output dresp_t resp
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);
    localparam int CNT_W = $clog2(LATENCY + 1);

    word_t mem [DEPTH_WORDS];

    logic [CNT_W-1:0] busy_cnt;    // cycles left before next request
    logic             pend_read;   // load waiting for its response
    word_t            rd_word;
    logic [IDX_W-1:0] idx;
    logic             accept;

    // word index, wraps at the depth
    assign idx    = req.addr[IDX_W+1:2];
    assign ready  = busy_cnt == '0;
    assign accept = req.valid && ready;

    // pulse lands LATENCY cycles after acceptance
    assign resp.valid = pend_read && (busy_cnt == CNT_W'(1));
    assign resp.rdata = rd_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt  <= '0;
            pend_read <= 1'b0;
        end else if (accept) begin
            busy_cnt  <= CNT_W'(LATENCY);
            pend_read <= !req.wen;
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == CNT_W'(1)) begin
                pend_read <= 1'b0;
            end
        end
    end

    // storage, byte lanes written under the mask
    always_ff @(posedge clk) begin
        if (accept) begin
            if (req.wen) begin
                for (int i = 0; i < 4; i++) begin
                    if (req.wmask[i]) begin
                        mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                    end
                end
            end else begin
                rd_word <= mem[idx];
            end
        end
    end

endmodule

/* load_extender.sv */
module load_extender
    import mem_types_pkg::*;
(
    input  logic [1:0] byte_off,
    input  mem_ctrl_t  ctrl,
    input  word_t      word,
    output word_t      result
);

    word_t shifted;
    logic  is_signed;

    // bring the addressed lane down to bit 0
    assign shifted   = word >> {byte_off, 3'b000};
    assign is_signed = ctrl.sel == MEM_LOAD_S;

    always_comb begin
        case (ctrl.size)
            SIZE_B: begin
                if (is_signed) begin
                    result = {{24{shifted[7]}}, shifted[7:0]};   // lb
                end else begin
                    result = {24'b0, shifted[7:0]};              // lbu
                end
            end
            SIZE_H: begin
                if (is_signed) begin
                    result = {{16{shifted[15]}}, shifted[15:0]}; // lh
                end else begin
                    result = {16'b0, shifted[15:0]};             // lhu
                end
            end
            default: result = word;  // lw, untouched
        endcase
    end

endmodule

/* store_aligner.sv */
module store_aligner
    import mem_types_pkg::*;
(
    input  logic [1:0] byte_off,
    input  mem_size_e  size,
    input  word_t      data,
    output word_t      wdata,
    output byte_mask_t wmask
);

    // data is replicated, mask picks the lane(s)
    always_comb begin
        case (size)
            SIZE_B: begin
                wdata = {4{data[7:0]}};
                wmask = byte_mask_t'(4'b0001 << byte_off);
            end
            SIZE_H: begin
                wdata = {2{data[15:0]}};
                // halfwords are aligned, only bit 1 matters
                wmask = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata = data;   // full word
                wmask = 4'b1111;
            end
        endcase
    end

endmodule

/* mem_stage_ctrl.sv */
module mem_stage_ctrl
    import mem_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       mem_valid,
    input  inst_id_t   inst_id,
    input  mem_ctrl_t  ctrl,
    input  addr_t      alu_out,
    input  word_t      st_wdata,
    input  byte_mask_t st_mask,
    input  logic       ready,
    input  dresp_t     resp,
    output dreq_t      req,
    output word_t      rdata_q,
    output logic       stall
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_VALID
    } state_e;

    state_e   state;
    logic     executed;    // saved_id already went through memory
    inst_id_t saved_id;

    logic is_mem;
    logic is_store;
    logic may_start;
    logic start;

    assign is_mem    = ctrl.sel != MEM_NONE;
    assign is_store  = ctrl.sel == MEM_STORE;
    // a held instruction must not hit memory a second time
    assign may_start = !executed || (saved_id != inst_id);
    assign start     = (state == IDLE) && mem_valid && is_mem && may_start;

    // raised in the same cycle a new access shows up
    assign stall = mem_valid && is_mem && ((state != IDLE) || may_start);

    assign req.valid = (state == WAIT_READY) && mem_valid && is_mem;
    assign req.wen   = is_store;
    assign req.addr  = alu_out;
    assign req.wdata = st_wdata;
    assign req.wmask = is_store ? st_mask : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            executed <= 1'b0;
        end else if (!mem_valid || !is_mem) begin
            state    <= IDLE;  // bubble or non-memory op, forget history
            executed <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (may_start) begin
                        state    <= WAIT_READY;
                        executed <= 1'b0;
                    end
                end
                WAIT_READY: begin
                    if (ready) begin
                        if (is_store) begin
                            state    <= IDLE;  // stores complete on acceptance
                            executed <= 1'b1;
                        end else begin
                            state <= WAIT_VALID;
                        end
                    end
                end
                WAIT_VALID: begin
                    if (resp.valid) begin
                        state    <= IDLE;
                        executed <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // id of the access in flight
    always_ff @(posedge clk) begin
        if (start) begin
            saved_id <= inst_id;
        end
    end

    // read word kept for writeback while the instruction is held
    always_ff @(posedge clk) begin
        if (state == WAIT_VALID && resp.valid) begin
            rdata_q <= resp.rdata;
        end
    end

endmodule

/* mem_bus_pkg.sv */
package mem_bus_pkg;

    import mem_types_pkg::*;

    // request from the stage toward data memory
    typedef struct packed {
        logic       valid;  // held until ready
        logic       wen;    // 1 = store
        addr_t      addr;
        word_t      wdata;  // already lane-shifted
        byte_mask_t wmask;
    } dreq_t;

    // read response, one-cycle pulse
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } dresp_t;

endpackage

/* mem_types_pkg.sv */
package mem_types_pkg;

    // widths that mean something on the datapath
    typedef logic [31:0] word_t;     // data word
    typedef logic [31:0] addr_t;     // byte address
    typedef logic [7:0]  inst_id_t;  // instruction tag
    typedef logic [3:0]  byte_mask_t; // one bit per byte lane

    // what the memory stage does with the instruction
    typedef enum logic [1:0] {
        MEM_NONE,    // no memory access
        MEM_STORE,
        MEM_LOAD_S,  // sign-extending load
        MEM_LOAD_U   // zero-extending load
    } mem_sel_e;

    // access width
    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    // memory control fields handed over from decode
    typedef struct packed {
        mem_sel_e  sel;
        mem_size_e size;
    } mem_ctrl_t;

endpackage
